/* logic/decode_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface decode_if import rv_isa_pkg::*, idu_pkg::*; ();

  alu_op_t  alu_op;
  word_t    imm;
  opsel_t   op1_sel;
  opsel_t   op2_sel;
  logic     swap_ops;
  logic     uses_rs1;
  logic     uses_rs2;
  logic     writes_rd;
  reg_idx_t rd;
  logic     is_jump;
  logic     is_load;
  logic     is_store;
  logic     illegal;

  modport decoder (
    output alu_op, imm, op1_sel, op2_sel, swap_ops, uses_rs1, uses_rs2,
    output writes_rd, rd, is_jump, is_load, is_store, illegal
  );

  modport issue (
    input alu_op, imm, op1_sel, op2_sel, swap_ops, uses_rs1, uses_rs2,
    input writes_rd, rd, is_jump, is_load, is_store, illegal
  );

endinterface

`default_nettype wire

/* logic/field_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module field_decoder import rv_isa_pkg::*, idu_pkg::*; (
  input  wire inst_t inst_i,
  decode_if.decoder  dec
);

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];

  // sign-extended immediates for each format
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    dec.alu_op    = ALU_ADD;
    dec.imm       = '0;
    dec.op1_sel   = OP1_ZERO;
    dec.op2_sel   = OP2_ZERO;
    dec.swap_ops  = 1'b0;
    dec.uses_rs1  = 1'b0;
    dec.uses_rs2  = 1'b0;
    dec.writes_rd = 1'b0;
    dec.rd        = inst_i[RD_LSB +: REG_IDX_W];
    dec.is_jump   = 1'b0;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.illegal   = 1'b0;

    case (opcode)
      OP_LUI: begin
        dec.imm       = imm_u;
        dec.op2_sel   = OP2_IMM;
        dec.writes_rd = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm       = imm_u;
        dec.op1_sel   = OP1_PC;
        dec.op2_sel   = OP2_IMM;
        dec.writes_rd = 1'b1;
      end
      OP_JAL: begin
        dec.imm       = imm_j;
        dec.op1_sel   = OP1_PC;
        dec.op2_sel   = OP2_FOUR;
        dec.writes_rd = 1'b1;
        dec.is_jump   = 1'b1;
      end
      OP_JALR: begin
        // rs1 feeds the target, so it still counts for hazards
        dec.imm       = imm_i;
        dec.op1_sel   = OP1_PC;
        dec.op2_sel   = OP2_FOUR;
        dec.uses_rs1  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.is_jump   = 1'b1;
      end
      OP_BRANCH: begin
        dec.imm      = imm_b;
        dec.op1_sel  = OP1_RS1;
        dec.op2_sel  = OP2_RS2;
        dec.uses_rs1 = 1'b1;
        dec.uses_rs2 = 1'b1;
        case (funct3)
          F3_BEQ:  dec.alu_op = ALU_SUB;
          F3_BNE:  dec.alu_op = ALU_XOR;
          F3_BLT:  dec.alu_op = ALU_SLT;
          F3_BLTU: dec.alu_op = ALU_SLTU;
          // a >= b is evaluated as b <= a
          F3_BGE: begin
            dec.alu_op   = ALU_SLE;
            dec.swap_ops = 1'b1;
          end
          F3_BGEU: begin
            dec.alu_op   = ALU_SLEU;
            dec.swap_ops = 1'b1;
          end
          default: dec.alu_op = ALU_ADD;
        endcase
      end
      OP_IMM: begin
        dec.imm       = imm_i;
        dec.op1_sel   = OP1_RS1;
        dec.op2_sel   = OP2_IMM;
        dec.uses_rs1  = 1'b1;
        dec.writes_rd = 1'b1;
        // the alt bit only matters for shift right, elsewhere it is immediate data
        dec.alu_op    = alu_op_t'({(funct3 == F3_SR) & inst_i[ALT_BIT], funct3});
      end
      OP_LOAD: begin
        dec.imm       = imm_i;
        dec.op1_sel   = OP1_RS1;
        dec.op2_sel   = OP2_IMM;
        dec.uses_rs1  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.is_load   = 1'b1;
        dec.alu_op    = alu_op_t'({1'b0, funct3});
      end
      OP_STORE: begin
        dec.imm      = imm_s;
        dec.op1_sel  = OP1_RS1;
        dec.op2_sel  = OP2_RS2;
        dec.uses_rs1 = 1'b1;
        dec.uses_rs2 = 1'b1;
        dec.is_store = 1'b1;
        dec.alu_op   = alu_op_t'({1'b0, funct3});
      end
      OP_REG: begin
        dec.op1_sel   = OP1_RS1;
        dec.op2_sel   = OP2_RS2;
        dec.uses_rs1  = 1'b1;
        dec.uses_rs2  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.alu_op    = alu_op_t'({inst_i[ALT_BIT], funct3});
      end
      OP_SYSTEM: begin
        dec.imm       = imm_i;
        dec.op1_sel   = OP1_RS1;
        dec.uses_rs1  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.alu_op    = alu_op_t'({1'b0, funct3});
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/idu_pkg.sv */
`default_nettype none

package idu_pkg;

  typedef logic [31:0] word_t;

  // encoding is {funct7[5], funct3} for OP and OP-IMM
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SLL  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SRL  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_AND  = 4'd7,
    ALU_SUB  = 4'd8,
    ALU_SLE  = 4'd10,
    ALU_SLEU = 4'd11,
    ALU_SRA  = 4'd13
  } alu_op_t;

  typedef enum logic {
    ISSUE_EMPTY,
    ISSUE_FULL
  } issue_state_t;

  // operand select codes
  typedef logic [1:0] opsel_t;

  localparam opsel_t OP1_RS1  = 2'd0;
  localparam opsel_t OP1_PC   = 2'd1;
  localparam opsel_t OP1_ZERO = 2'd2;

  localparam opsel_t OP2_RS2  = 2'd0;
  localparam opsel_t OP2_IMM  = 2'd1;
  localparam opsel_t OP2_FOUR = 2'd2;
  localparam opsel_t OP2_ZERO = 2'd3;

  // return address offset for jal and jalr
  localparam word_t LINK_OFFSET = 32'd4;

endpackage

`default_nettype wire

/* logic/idu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module idu_top import rv_isa_pkg::*, idu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     inst_valid_i,
  input  wire inst_t    inst_i,
  input  wire word_t    pc_i,
  output logic          inst_ready_o,
  input  wire logic     wb_valid_i,
  input  wire reg_idx_t wb_rd_i,
  input  wire word_t    wb_data_i,
  input  wire logic     ex_valid_i,
  input  wire reg_idx_t ex_rd_i,
  input  wire word_t    ex_data_i,
  output logic          issue_valid_o,
  input  wire logic     issue_ready_i,
  output alu_op_t       alu_op_o,
  output word_t         op1_o,
  output word_t         op2_o,
  output word_t         imm_o,
  output reg_idx_t      rd_o,
  output word_t         mem_addr_o,
  output logic          jump_o,
  output logic          load_o,
  output logic          store_o,
  output logic          illegal_o,
  output word_t         pc_o
);

  word_t    rs1_data;
  word_t    rs2_data;
  logic     rs1_busy;
  logic     rs2_busy;
  word_t    rs1_val;
  word_t    rs2_val;
  logic     hazard;
  logic     claim_valid;
  reg_idx_t claim_rd;

  decode_if dec_bus ();

  reg_file u_reg_file (
    .clk           (clk),
    .rst           (rst),
    .rs1_i         (inst_i[RS1_LSB +: REG_IDX_W]),
    .rs2_i         (inst_i[RS2_LSB +: REG_IDX_W]),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data),
    .rs1_busy_o    (rs1_busy),
    .rs2_busy_o    (rs2_busy),
    .wb_valid_i    (wb_valid_i),
    .wb_rd_i       (wb_rd_i),
    .wb_data_i     (wb_data_i),
    .claim_valid_i (claim_valid),
    .claim_rd_i    (claim_rd)
  );

  field_decoder u_field_decoder (
    .inst_i (inst_i),
    .dec    (dec_bus.decoder)
  );

  // runs beside the decoder, only the source-use flags cross over
  operand_bypass u_operand_bypass (
    .rs1_idx_i  (inst_i[RS1_LSB +: REG_IDX_W]),
    .rs2_idx_i  (inst_i[RS2_LSB +: REG_IDX_W]),
    .uses_rs1_i (dec_bus.uses_rs1),
    .uses_rs2_i (dec_bus.uses_rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_busy_i (rs1_busy),
    .rs2_busy_i (rs2_busy),
    .ex_valid_i (ex_valid_i),
    .ex_rd_i    (ex_rd_i),
    .ex_data_i  (ex_data_i),
    .rs1_val_o  (rs1_val),
    .rs2_val_o  (rs2_val),
    .hazard_o   (hazard)
  );

  issue_reg u_issue_reg (
    .clk           (clk),
    .rst           (rst),
    .inst_valid_i  (inst_valid_i),
    .inst_ready_o  (inst_ready_o),
    .pc_i          (pc_i),
    .dec           (dec_bus.issue),
    .rs1_val_i     (rs1_val),
    .rs2_val_i     (rs2_val),
    .hazard_i      (hazard),
    .claim_valid_o (claim_valid),
    .claim_rd_o    (claim_rd),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .alu_op_o      (alu_op_o),
    .op1_o         (op1_o),
    .op2_o         (op2_o),
    .imm_o         (imm_o),
    .rd_o          (rd_o),
    .mem_addr_o    (mem_addr_o),
    .jump_o        (jump_o),
    .load_o        (load_o),
    .store_o       (store_o),
    .illegal_o     (illegal_o),
    .pc_o          (pc_o)
  );

endmodule

`default_nettype wire

/* logic/issue_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_reg import rv_isa_pkg::*, idu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     inst_valid_i,
  output logic          inst_ready_o,
  input  wire word_t    pc_i,
  decode_if.issue       dec,
  input  wire word_t    rs1_val_i,
  input  wire word_t    rs2_val_i,
  input  wire logic     hazard_i,
  output logic          claim_valid_o,
  output reg_idx_t      claim_rd_o,
  output logic          issue_valid_o,
  input  wire logic     issue_ready_i,
  output alu_op_t       alu_op_o,
  output word_t         op1_o,
  output word_t         op2_o,
  output word_t         imm_o,
  output reg_idx_t      rd_o,
  output word_t         mem_addr_o,
  output logic          jump_o,
  output logic          load_o,
  output logic          store_o,
  output logic          illegal_o,
  output word_t         pc_o
);

  issue_state_t state_q;
  issue_state_t state_d;
  logic         accept;
  word_t        op1_raw;
  word_t        op2_raw;
  word_t        mem_addr;

  // slot can take a new entry when empty or draining this cycle
  assign inst_ready_o = !hazard_i && (state_q == ISSUE_EMPTY || issue_ready_i);
  assign accept       = inst_valid_i && inst_ready_o;

  assign claim_valid_o = accept && dec.writes_rd && dec.rd != '0;
  assign claim_rd_o    = dec.rd;

  always_comb begin
    case (dec.op1_sel)
      OP1_RS1: op1_raw = rs1_val_i;
      OP1_PC:  op1_raw = pc_i;
      default: op1_raw = '0;
    endcase
    case (dec.op2_sel)
      OP2_RS2:  op2_raw = rs2_val_i;
      OP2_IMM:  op2_raw = dec.imm;
      OP2_FOUR: op2_raw = LINK_OFFSET;
      default:  op2_raw = '0;
    endcase
  end

  assign mem_addr = (dec.is_load || dec.is_store) ? rs1_val_i + dec.imm : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISSUE_EMPTY: if (accept) state_d = ISSUE_FULL;
      ISSUE_FULL:  if (issue_ready_i && !accept) state_d = ISSUE_EMPTY;
      default:     state_d = ISSUE_EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ISSUE_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // bundle is loaded only on acceptance and holds otherwise
  always_ff @(posedge clk) begin
    if (accept) begin
      alu_op_o   <= dec.alu_op;
      op1_o      <= dec.swap_ops ? op2_raw : op1_raw;
      op2_o      <= dec.swap_ops ? op1_raw : op2_raw;
      imm_o      <= dec.imm;
      rd_o       <= dec.rd;
      mem_addr_o <= mem_addr;
      jump_o     <= dec.is_jump;
      load_o     <= dec.is_load;
      store_o    <= dec.is_store;
      illegal_o  <= dec.illegal;
      pc_o       <= pc_i;
    end
  end

  assign issue_valid_o = (state_q == ISSUE_FULL);

endmodule

`default_nettype wire

/* logic/operand_bypass.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_bypass import rv_isa_pkg::*, idu_pkg::*; (
  input  wire reg_idx_t rs1_idx_i,
  input  wire reg_idx_t rs2_idx_i,
  input  wire logic     uses_rs1_i,
  input  wire logic     uses_rs2_i,
  input  wire word_t    rs1_data_i,
  input  wire word_t    rs2_data_i,
  input  wire logic     rs1_busy_i,
  input  wire logic     rs2_busy_i,
  input  wire logic     ex_valid_i,
  input  wire reg_idx_t ex_rd_i,
  input  wire word_t    ex_data_i,
  output word_t         rs1_val_o,
  output word_t         rs2_val_o,
  output logic          hazard_o
);

  logic fwd1;
  logic fwd2;
  logic stall1;
  logic stall2;

  // execute result targets this source register
  function automatic logic fwd_hit(reg_idx_t idx);
    return ex_valid_i && ex_rd_i == idx && idx != '0;
  endfunction

  function automatic word_t pick(reg_idx_t idx, logic hit, word_t rf_data);
    if (idx == '0) begin
      return '0;
    end
    return hit ? ex_data_i : rf_data;
  endfunction

  assign fwd1 = fwd_hit(rs1_idx_i);
  assign fwd2 = fwd_hit(rs2_idx_i);

  assign rs1_val_o = pick(rs1_idx_i, fwd1, rs1_data_i);
  assign rs2_val_o = pick(rs2_idx_i, fwd2, rs2_data_i);

  // outstanding result with no forward to cover it
  assign stall1 = uses_rs1_i && rs1_idx_i != '0 && rs1_busy_i && !fwd1;
  assign stall2 = uses_rs2_i && rs2_idx_i != '0 && rs2_busy_i && !fwd2;

  assign hazard_o = stall1 || stall2;

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_isa_pkg::*, idu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire reg_idx_t rs1_i,
  input  wire reg_idx_t rs2_i,
  output word_t         rs1_data_o,
  output word_t         rs2_data_o,
  output logic          rs1_busy_o,
  output logic          rs2_busy_o,
  input  wire logic     wb_valid_i,
  input  wire reg_idx_t wb_rd_i,
  input  wire word_t    wb_data_i,
  input  wire logic     claim_valid_i,
  input  wire reg_idx_t claim_rd_i
);

  word_t                regs [NUM_REGS];
  logic  [NUM_REGS-1:0] busy;

  // x0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // write-back releases a register, a new claim on the same one wins
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (wb_valid_i && wb_rd_i != '0) begin
        busy[wb_rd_i] <= 1'b0;
      end
      if (claim_valid_i && claim_rd_i != '0) begin
        busy[claim_rd_i] <= 1'b1;
      end
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];
  assign rs1_busy_o = busy[rs1_i];
  assign rs2_busy_o = busy[rs2_i];

endmodule

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // RV32E has 16 architectural registers
  localparam int NUM_REGS  = 16;
  localparam int REG_IDX_W = 4;

  typedef logic [31:0]          inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [6:0]           opcode_t;

  // instruction field positions, low bit of each index field
  localparam int RD_LSB  = 7;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  // funct7 bit that selects SUB and SRA
  localparam int ALT_BIT = 30;

  // major opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // branch funct3 codes
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // shift right, logical or arithmetic by funct7
  localparam logic [2:0] F3_SR = 3'b101;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the decode-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module idu_tb -o idu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/idu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sources.f */
logic/rv_isa_pkg.sv
logic/idu_pkg.sv
logic/decode_if.sv
logic/reg_file.sv
logic/field_decoder.sv
logic/operand_bypass.sv
logic/issue_reg.sv
logic/idu_top.sv
verification/idu_asserts.sv
verification/idu_tb.sv

/* verification/idu_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module idu_asserts (
  input wire logic        clk,
  input wire logic        rst,
  input wire logic [31:0] inst_i,
  input wire logic        inst_ready_o,
  input wire logic        uses_rs1,
  input wire logic        uses_rs2,
  input wire logic        rs1_busy,
  input wire logic        rs2_busy,
  input wire logic        ex_valid_i,
  input wire logic [3:0]  ex_rd_i,
  input wire logic        issue_valid_o,
  input wire logic        issue_ready_i,
  input wire logic [3:0]  alu_op_o,
  input wire logic [31:0] op1_o,
  input wire logic [31:0] op2_o,
  input wire logic [31:0] imm_o,
  input wire logic [3:0]  rd_o,
  input wire logic [31:0] mem_addr_o,
  input wire logic        jump_o,
  input wire logic        load_o,
  input wire logic        store_o,
  input wire logic        illegal_o,
  input wire logic [31:0] pc_o
);

  logic [3:0] rs1_idx;
  logic [3:0] rs2_idx;
  logic       rs1_blocked;
  logic       rs2_blocked;

  // source index fields of the instruction at the input
  assign rs1_idx = inst_i[18:15];
  assign rs2_idx = inst_i[23:20];

  // busy source with no matching execute forward
  assign rs1_blocked = uses_rs1 && rs1_idx != 4'd0 && rs1_busy &&
                       !(ex_valid_i && ex_rd_i == rs1_idx);
  assign rs2_blocked = uses_rs2 && rs2_idx != 4'd0 && rs2_busy &&
                       !(ex_valid_i && ex_rd_i == rs2_idx);

  // slot is empty once reset has been seen
  reset_empty: assert property (@(posedge clk) rst |=> !issue_valid_o)
    else $error("issue_valid_o high after reset");

  // a stalled bundle must not change
  hold_stable: assert property (@(posedge clk) disable iff (rst)
    issue_valid_o && !issue_ready_i |=> issue_valid_o &&
      $stable({alu_op_o, op1_o, op2_o, imm_o, rd_o, mem_addr_o,
               jump_o, load_o, store_o, illegal_o, pc_o}))
    else $error("issue bundle changed under back-pressure");

  no_ready_on_hazard: assert property (@(posedge clk) disable iff (rst)
    (rs1_blocked || rs2_blocked) |-> !inst_ready_o)
    else $error("inst_ready_o high during a hazard");

endmodule

bind idu_top idu_asserts u_idu_asserts (
  .clk           (clk),
  .rst           (rst),
  .inst_i        (inst_i),
  .inst_ready_o  (inst_ready_o),
  .uses_rs1      (dec_bus.uses_rs1),
  .uses_rs2      (dec_bus.uses_rs2),
  .rs1_busy      (rs1_busy),
  .rs2_busy      (rs2_busy),
  .ex_valid_i    (ex_valid_i),
  .ex_rd_i       (ex_rd_i),
  .issue_valid_o (issue_valid_o),
  .issue_ready_i (issue_ready_i),
  .alu_op_o      (alu_op_o),
  .op1_o         (op1_o),
  .op2_o         (op2_o),
  .imm_o         (imm_o),
  .rd_o          (rd_o),
  .mem_addr_o    (mem_addr_o),
  .jump_o        (jump_o),
  .load_o        (load_o),
  .store_o       (store_o),
  .illegal_o     (illegal_o),
  .pc_o          (pc_o)
);

`default_nettype wire

/* verification/idu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module idu_tb;

  localparam int NROWS = 22;
  localparam int LIMIT = NROWS * 40;

  // row kinds
  localparam int K_WB   = 0;
  localparam int K_INST = 1;
  localparam int K_FWD  = 2;
  localparam int K_HOLD = 3;
  localparam int K_HAZ  = 4;

  // flag bits {jump, load, store, illegal}
  localparam logic [31:0] F_JUMP  = 32'd8;
  localparam logic [31:0] F_LOAD  = 32'd4;
  localparam logic [31:0] F_STORE = 32'd2;
  localparam logic [31:0] F_ILL   = 32'd1;

  logic        clk;
  logic        rst;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        inst_ready_o;
  logic        wb_valid_i;
  logic [3:0]  wb_rd_i;
  logic [31:0] wb_data_i;
  logic        ex_valid_i;
  logic [3:0]  ex_rd_i;
  logic [31:0] ex_data_i;
  logic        issue_valid_o;
  logic        issue_ready_i;
  logic [3:0]  alu_op_o;
  logic [31:0] op1_o;
  logic [31:0] op2_o;
  logic [31:0] imm_o;
  logic [3:0]  rd_o;
  logic [31:0] mem_addr_o;
  logic        jump_o;
  logic        load_o;
  logic        store_o;
  logic        illegal_o;
  logic [31:0] pc_o;

  int          tab_kind [NROWS];
  logic [31:0] tab_inst [NROWS];
  logic [31:0] tab_pc   [NROWS];
  logic [3:0]  tab_rd   [NROWS];
  logic [31:0] tab_data [NROWS];
  int          tab_cnt  [NROWS];
  logic [3:0]  tab_alu  [NROWS];
  logic [31:0] tab_op1  [NROWS];
  logic [31:0] tab_op2  [NROWS];
  logic [31:0] tab_imm  [NROWS];
  logic [31:0] tab_mem  [NROWS];
  logic [3:0]  tab_flag [NROWS];
  // expected destination, negative where the instruction writes none
  int          tab_dst  [NROWS];
  int          nrows = 0;
  int          cycles = 0;

  idu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      fail_now("simulation timed out before the table finished");
    end
  end

  task automatic add_row(input int k, input logic [31:0] ins, pc, r, d, input int cnt,
                         input logic [31:0] alu, o1, o2, im, ma, fl, input int dst);
    tab_kind[nrows] = k;
    tab_inst[nrows] = ins;
    tab_pc[nrows]   = pc;
    tab_rd[nrows]   = r[3:0];
    tab_data[nrows] = d;
    tab_cnt[nrows]  = cnt;
    tab_alu[nrows]  = alu[3:0];
    tab_op1[nrows]  = o1;
    tab_op2[nrows]  = o2;
    tab_imm[nrows]  = im;
    tab_mem[nrows]  = ma;
    tab_flag[nrows] = fl[3:0];
    tab_dst[nrows]  = dst;
    nrows++;
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] got, exp);
    assert (got === exp) else
      fail_now($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_bundle(input int i);
    assert (issue_valid_o) else fail_now("issue_valid_o is low where a bundle is expected");
    compare("alu_op", {28'd0, alu_op_o}, {28'd0, tab_alu[i]});
    compare("op1", op1_o, tab_op1[i]);
    compare("op2", op2_o, tab_op2[i]);
    compare("imm", imm_o, tab_imm[i]);
    compare("mem_addr", mem_addr_o, tab_mem[i]);
    compare("flags", {28'd0, jump_o, load_o, store_o, illegal_o}, {28'd0, tab_flag[i]});
    compare("pc", pc_o, tab_pc[i]);
    if (tab_dst[i] >= 0) begin
      compare("rd", {28'd0, rd_o}, tab_dst[i]);
    end
  endtask

  // holds the instruction valid until the edge that accepts it
  task automatic apply_inst(input int i, output int waited);
    logic ready;
    waited = 0;
    inst_i = tab_inst[i];
    pc_i = tab_pc[i];
    inst_valid_i = 1'b1;
    ready = 1'b0;
    while (!ready) begin
      @(negedge clk);
      ready = inst_ready_o;
      next_cycle();
      if (!ready) waited++;
    end
    inst_valid_i = 1'b0;
  endtask

  task automatic expect_stall(input string what);
    @(negedge clk);
    assert (!inst_ready_o) else fail_now(what);
    next_cycle();
  endtask

  initial begin
    int n;
    inst_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    wb_valid_i = 1'b0;
    wb_rd_i = '0;
    wb_data_i = '0;
    ex_valid_i = 1'b0;
    ex_rd_i = '0;
    ex_data_i = '0;
    issue_ready_i = 1'b1;
    rst = 1'b1;

    // x3 = 16, x5 = -16
    add_row(K_WB, 0, 0, 3, 32'h10, 0, 0, 0, 0, 0, 0, 0, -1);
    add_row(K_WB, 0, 0, 5, 32'hFFFF_FFF0, 0, 0, 0, 0, 0, 0, 0, -1);
    // addi x1,x3,-5 and srai x2,x5,4
    add_row(K_INST, 32'hFFB1_8093, 32'h10, 0, 0, 0, 0, 32'h10, 32'hFFFF_FFFB,
            32'hFFFF_FFFB, 0, 0, 1);
    add_row(K_INST, 32'h4042_D113, 32'h14, 0, 0, 0, 13, 32'hFFFF_FFF0, 32'h404, 32'h404,
            0, 0, 2);
    // sub x4,x3,x5 and add x6,x0,x5
    add_row(K_INST, 32'h4051_8233, 32'h18, 0, 0, 0, 8, 32'h10, 32'hFFFF_FFF0, 0, 0, 0, 4);
    add_row(K_INST, 32'h0050_0333, 32'h1C, 0, 0, 0, 0, 0, 32'hFFFF_FFF0, 0, 0, 0, 6);
    // lui, auipc, jal
    add_row(K_INST, 32'h1234_5437, 32'h20, 0, 0, 0, 0, 0, 32'h1234_5000, 32'h1234_5000,
            0, 0, 8);
    add_row(K_INST, 32'h0000_1497, 32'h100, 0, 0, 0, 0, 32'h100, 32'h1000, 32'h1000, 0, 0, 9);
    add_row(K_INST, 32'h0080_056F, 32'h200, 0, 0, 0, 0, 32'h200, 32'h4, 32'h8, 0, F_JUMP, 10);
    // branches on x3, x5 with offset 16
    add_row(K_INST, 32'h0051_8863, 32'h300, 0, 0, 0, 8, 32'h10, 32'hFFFF_FFF0, 32'h10,
            0, 0, -1);
    add_row(K_INST, 32'h0051_9863, 32'h304, 0, 0, 0, 4, 32'h10, 32'hFFFF_FFF0, 32'h10,
            0, 0, -1);
    add_row(K_INST, 32'h0051_C863, 32'h308, 0, 0, 0, 2, 32'h10, 32'hFFFF_FFF0, 32'h10,
            0, 0, -1);
    add_row(K_INST, 32'h0051_D863, 32'h30C, 0, 0, 0, 10, 32'hFFFF_FFF0, 32'h10, 32'h10,
            0, 0, -1);
    add_row(K_INST, 32'h0051_E863, 32'h310, 0, 0, 0, 3, 32'h10, 32'hFFFF_FFF0, 32'h10,
            0, 0, -1);
    add_row(K_INST, 32'h0051_F863, 32'h314, 0, 0, 0, 11, 32'hFFFF_FFF0, 32'h10, 32'h10,
            0, 0, -1);
    // lw x11,-4(x3) and sw x5,8(x3)
    add_row(K_INST, 32'hFFC1_A583, 32'h400, 0, 0, 0, 2, 32'h10, 32'hFFFF_FFFC,
            32'hFFFF_FFFC, 32'hC, F_LOAD, 11);
    add_row(K_INST, 32'h0051_A423, 32'h404, 0, 0, 0, 2, 32'h10, 32'hFFFF_FFF0, 32'h8,
            32'h18, F_STORE, -1);
    // add x12,x1,x3 waits for write-back of x1
    add_row(K_HAZ, 32'h0030_8633, 32'h500, 1, 32'h55, 3, 0, 32'h55, 32'h10, 0, 0, 0, 12);
    // add x13,x2,x0 with x2 forwarded from execute
    add_row(K_FWD, 32'h0001_06B3, 32'h504, 2, 32'hCAFE_0000, 0, 0, 32'hCAFE_0000, 0, 0, 0, 0,
            13);
    // xor under back-pressure, then or
    add_row(K_HOLD, 32'h0051_C733, 32'h600, 0, 0, 4, 4, 32'h10, 32'hFFFF_FFF0, 0, 0, 0, 14);
    add_row(K_INST, 32'h0051_E7B3, 32'h604, 0, 0, 0, 6, 32'h10, 32'hFFFF_FFF0, 0, 0, 0, 15);
    // opcode 7'h7f is not decoded
    add_row(K_INST, 32'h0000_007F, 32'h700, 0, 0, 0, 0, 0, 0, 0, 0, F_ILL, -1);

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < nrows; i++) begin
      case (tab_kind[i])
        K_WB: begin
          wb_valid_i = 1'b1;
          wb_rd_i = tab_rd[i];
          wb_data_i = tab_data[i];
          next_cycle();
          wb_valid_i = 1'b0;
        end
        K_FWD: begin
          ex_valid_i = 1'b1;
          ex_rd_i = tab_rd[i];
          ex_data_i = tab_data[i];
          apply_inst(i, n);
          ex_valid_i = 1'b0;
          assert (n == 0) else fail_now("forwarded instruction was not accepted at once");
          check_bundle(i);
        end
        K_HAZ: begin
          inst_i = tab_inst[i];
          pc_i = tab_pc[i];
          inst_valid_i = 1'b1;
          repeat (tab_cnt[i]) expect_stall("instruction accepted while its source is busy");
          wb_valid_i = 1'b1;
          wb_rd_i = tab_rd[i];
          wb_data_i = tab_data[i];
          next_cycle();
          wb_valid_i = 1'b0;
          apply_inst(i, n);
          check_bundle(i);
        end
        K_HOLD: begin
          apply_inst(i, n);
          issue_ready_i = 1'b0;
          check_bundle(i);
          // the next row waits at the input while the slot is blocked
          inst_i = tab_inst[i+1];
          pc_i = tab_pc[i+1];
          inst_valid_i = 1'b1;
          repeat (tab_cnt[i]) begin
            expect_stall("next instruction accepted under back-pressure");
            check_bundle(i);
          end
          issue_ready_i = 1'b1;
        end
        default: begin
          apply_inst(i, n);
          check_bundle(i);
        end
      endcase
    end

    next_cycle();
    assert (!issue_valid_o) else fail_now("an extra bundle issued after the last instruction");
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
